// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     := --timing --assert
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary
TOP        := loader_tb
FILELIST   := verilog.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG) || \
		! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/led_chaser.sv ====
`timescale 1ns/1ps

`include "loader_defines.svh"

module led_chaser (
	input  logic                      clk,
	input  logic                      rst,
	input  loader_pkg::loader_state_e state,
	output logic [7:0]                led
);
	import loader_pkg::*;

	logic [`LOADER_LED_DIV_W-1:0] div;
	logic                         step;

	assign step = &div; // one step per divider wrap.

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			div <= '0;
			led <= 8'd1;
		end else begin
			div <= div + 1'b1;
			if (step) begin
				unique case (state)
					st_load: begin
						led <= {led[6:0], led[7]}; // left while loading.
					end
					st_idle, st_dump: begin
						led <= {led[0], led[7:1]}; // right while the cpu waits.
					end
					default: begin
						led <= led; // still while running.
					end
				endcase
			end
		end
	end

endmodule

// ==== logic/loader_counter.sv ====
`timescale 1ns/1ps

`include "loader_defines.svh"

module loader_counter (
	input  logic                      clk,
	input  logic                      rst,
	input  loader_pkg::loader_state_e state,
	input  logic                      rx_valid,
	input  logic [`LOADER_DATA_W-1:0] rx_data,
	input  logic                      dump_memory,
	input  logic                      tx_done,
	output loader_pkg::mem_req_t      loader_req,
	output logic                      tx_wr,
	output logic                      load_last,
	output logic                      dump_last,
	output logic                      byte_sent
);
	import loader_pkg::*;

	// settle timer steps, the write fires two cycles after a byte.
	localparam logic [1:0] settle_start = 2'd0;
	localparam logic [1:0] settle_fire  = 2'd1;
	localparam logic [1:0] settle_idle  = 2'd3;

	logic [`LOADER_ADDR_W-1:0] wr_addr;
	logic [`LOADER_ADDR_W-1:0] rd_addr;
	logic [`LOADER_DATA_W-1:0] wr_data;
	logic [1:0]                settle;
	logic                      loading;
	logic                      rx_take;
	logic                      wr_strobe;
	logic                      dump_start;
	logic                      rd_step;
	logic                      tx_kick;
	logic                      tx_pend;

	assign loading    = (state == st_idle) || (state == st_load);
	assign rx_take    = rx_valid && loading; // bytes after the load are dropped.
	assign wr_strobe  = (settle == settle_fire) && loading;
	assign dump_start = dump_memory && (state == st_run);
	assign rd_step    = tx_done && (state == st_dump);

	assign load_last = wr_strobe && (&wr_addr);
	assign dump_last = rd_step && (&rd_addr);
	assign byte_sent = rd_step && !(&rd_addr);

	// write address and settle timer.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_addr <= '1; // first byte wraps to address 0.
			settle  <= settle_idle;
		end else if (rx_take) begin
			wr_addr <= wr_addr + 1'b1;
			settle  <= settle_start; // a new byte restarts the timer.
		end else if (settle != settle_idle) begin
			settle <= settle + 1'b1;
		end
	end

	// received byte, held until its write.
	always_ff @(posedge clk) begin
		if (rx_take) begin
			wr_data <= rx_data;
		end
	end

	// read address for the dump.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_addr <= '0;
		end else if (dump_start) begin
			rd_addr <= '0;
		end else if (byte_sent) begin
			rd_addr <= rd_addr + 1'b1;
		end
	end

	// a read address change needs one cycle for the ram read.
	assign tx_kick = dump_start || byte_sent;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tx_pend <= 1'b0;
			tx_wr   <= 1'b0;
		end else begin
			tx_pend <= tx_kick;
			tx_wr   <= tx_pend; // rdata is valid here.
		end
	end

	always_comb begin
		loader_req.addr  = loading ? wr_addr : rd_addr;
		loader_req.wr    = wr_strobe;
		loader_req.wdata = wr_data;
	end

endmodule

// ==== logic/loader_defines.svh ====
`ifndef LOADER_DEFINES_SVH
`define LOADER_DEFINES_SVH

// program RAM geometry, 64 bytes.
`define LOADER_ADDR_W 6
`define LOADER_DATA_W 8

// led divider, short for simulation.
`define LOADER_LED_DIV_W 4

`endif

// ==== logic/loader_fsm.sv ====
`timescale 1ns/1ps

module loader_fsm (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      rx_valid,
	input  logic                      dump_memory,
	input  logic                      load_last,
	input  logic                      dump_last,
	output loader_pkg::loader_state_e state,
	output logic                      cpu_rst
);
	import loader_pkg::*;

	loader_state_e state_next;

	// phase sequencing, loading happens once only.
	always_comb begin
		state_next = state;
		unique case (state)
			st_idle: begin
				if (rx_valid) begin
					state_next = st_load; // first byte starts the load.
				end
			end
			st_load: begin
				if (load_last) begin
					state_next = st_run; // ram full, hand over to cpu.
				end
			end
			st_run: begin
				if (dump_memory) begin
					state_next = st_dump;
				end
			end
			st_dump: begin
				if (dump_last) begin
					state_next = st_run; // last byte acknowledged.
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	// cpu reset follows the next phase, so it moves with the state.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state   <= st_idle;
			cpu_rst <= 1'b1;
		end else begin
			state   <= state_next;
			cpu_rst <= (state_next != st_run); // only run frees the cpu.
		end
	end

endmodule

// ==== logic/loader_pkg.sv ====
`include "loader_defines.svh"

package loader_pkg;

	// loader phase.
	typedef enum logic [1:0] {
		st_idle = 2'd0, // held after reset.
		st_load = 2'd1, // bytes arriving.
		st_run  = 2'd2, // cpu owns the ram.
		st_dump = 2'd3  // ram going out to the transmitter.
	} loader_state_e;

	// one ram access, from the loader or the cpu.
	typedef struct packed {
		logic [`LOADER_ADDR_W-1:0] addr;
		logic                      wr;
		logic [`LOADER_DATA_W-1:0] wdata;
	} mem_req_t;

endpackage

// ==== logic/loader_top.sv ====
`timescale 1ns/1ps

`include "loader_defines.svh"

module loader_top (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      rx_valid,
	input  logic [`LOADER_DATA_W-1:0] rx_data,
	input  logic                      dump_memory,
	input  logic                      tx_done,
	input  loader_pkg::mem_req_t      cpu_req,
	output logic                      cpu_rst,
	output logic [`LOADER_DATA_W-1:0] cpu_rdata,
	output logic                      tx_wr,
	output logic [`LOADER_DATA_W-1:0] tx_data,
	output logic [7:0]                led
);
	import loader_pkg::*;

	loader_state_e state;
	mem_req_t      loader_req;
	logic          load_last;
	logic          dump_last;
	logic          byte_sent; // per-byte dump progress.

	loader_fsm i_fsm (
		.clk         (clk),
		.rst         (rst),
		.rx_valid    (rx_valid),
		.dump_memory (dump_memory),
		.load_last   (load_last),
		.dump_last   (dump_last),
		.state       (state),
		.cpu_rst     (cpu_rst)
	);

	loader_counter i_counter (
		.clk         (clk),
		.rst         (rst),
		.state       (state),
		.rx_valid    (rx_valid),
		.rx_data     (rx_data),
		.dump_memory (dump_memory),
		.tx_done     (tx_done),
		.loader_req  (loader_req),
		.tx_wr       (tx_wr),
		.load_last   (load_last),
		.dump_last   (dump_last),
		.byte_sent   (byte_sent)
	);

	prog_ram i_ram (
		.clk        (clk),
		.state      (state),
		.loader_req (loader_req),
		.cpu_req    (cpu_req),
		.rdata      (cpu_rdata)
	);

	// the transmitter sees the same read port as the cpu.
	assign tx_data = cpu_rdata;

	led_chaser i_led (
		.clk   (clk),
		.rst   (rst),
		.state (state),
		.led   (led)
	);

endmodule

// ==== logic/prog_ram.sv ====
`timescale 1ns/1ps

`include "loader_defines.svh"

module prog_ram (
	input  logic                      clk,
	input  loader_pkg::loader_state_e state,
	input  loader_pkg::mem_req_t      loader_req,
	input  loader_pkg::mem_req_t      cpu_req,
	output logic [`LOADER_DATA_W-1:0] rdata
);
	import loader_pkg::*;

	localparam int depth = 2 ** `LOADER_ADDR_W;

	logic [`LOADER_DATA_W-1:0] mem [depth];
	mem_req_t                  req;

	// cpu owns the port only while running.
	assign req = (state == st_run) ? cpu_req : loader_req;

	always_ff @(posedge clk) begin
		if (req.wr) begin
			mem[req.addr] <= req.wdata;
		end
		rdata <= mem[req.addr]; // read before write.
	end

endmodule

// ==== sim/loader_chk.sv ====
`timescale 1ns/1ps

module loader_chk (
	input logic                      clk,
	input logic                      rst,
	input logic                      tx_wr,
	input logic                      byte_sent,
	input logic                      cpu_rst,
	input loader_pkg::loader_state_e state,
	input logic [7:0]                led
);
	import loader_pkg::*;

	// one strobe per byte handed to the transmitter.
	tx_wr_single: assert property (@(posedge clk) disable iff (rst)
		tx_wr |=> !tx_wr)
		else $error("tx_wr high in two consecutive cycles");

	// each acknowledged byte brings the next strobe two cycles later.
	tx_wr_follows: assert property (@(posedge clk) disable iff (rst)
		byte_sent |-> ##2 tx_wr)
		else $error("tx_wr missing two cycles after byte_sent");

	// the cpu runs only in st_run.
	cpu_rst_run: assert property (@(posedge clk) disable iff (rst)
		!cpu_rst |-> (state == st_run))
		else $error("cpu_rst low outside st_run");

	led_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot(led))
		else $error("led pattern is not one-hot");

endmodule

bind loader_top loader_chk i_chk (
	.clk       (clk),
	.rst       (rst),
	.tx_wr     (tx_wr),
	.byte_sent (byte_sent),
	.cpu_rst   (cpu_rst),
	.state     (state),
	.led       (led)
);

// ==== sim/loader_tb.sv ====
`timescale 1ns/1ps

`include "loader_defines.svh"

module loader_tb;
	import loader_pkg::*;

	localparam int depth = 1 << `LOADER_ADDR_W;
	localparam int byte_gap = 4; // cycles between received bytes.
	localparam int wait_limit = 16; // cycles allowed for one tx_wr.
	// 64 loads x 4 plus two dumps x 64 x 8 is about 1300 cycles.
	localparam int max_cycles = 20000;

	logic                      clk;
	logic                      rst;
	logic                      rx_valid;
	logic [`LOADER_DATA_W-1:0] rx_data;
	logic                      dump_memory;
	logic                      tx_done;
	mem_req_t                  cpu_req;
	logic                      cpu_rst;
	logic [`LOADER_DATA_W-1:0] cpu_rdata;
	logic                      tx_wr;
	logic [`LOADER_DATA_W-1:0] tx_data;
	logic [7:0]                led;

	logic [`LOADER_DATA_W-1:0] model_mem [depth]; // expected ram contents.
	logic [31:0]               lcg_state;
	logic [7:0]                led_prev;
	int                        cycles = 0;
	int                        errors = 0;
	int                        checks = 0;
	int                        tests = 0;
	int                        failed_tests = 0;
	int                        start_errors = 0;

	loader_top i_dut (
		.clk         (clk),
		.rst         (rst),
		.rx_valid    (rx_valid),
		.rx_data     (rx_data),
		.dump_memory (dump_memory),
		.tx_done     (tx_done),
		.cpu_req     (cpu_req),
		.cpu_rst     (cpu_rst),
		.cpu_rdata   (cpu_rdata),
		.tx_wr       (tx_wr),
		.tx_data     (tx_data),
		.led         (led)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic check_value(input string what, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	// one-hot and either still or one step left.
	task automatic check_led_left();
		logic [7:0] rotated;
		rotated = {led_prev[6:0], led_prev[7]};
		checks++;
		assert ($onehot(led) && (led == led_prev || led == rotated)) else begin
			errors++;
			$display("error at %0t ns: led went from %b to %b while loading",
				$time, led_prev, led);
		end
		led_prev = led;
	endtask

	task automatic report_test(input string name);
		int n;
		n = errors - start_errors;
		tests++;
		if (n == 0) begin
			$display("%s: passed", name);
		end else begin
			failed_tests++;
			$display("%s: failed with %0d errors", name, n);
		end
		start_errors = errors;
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
	endtask

	task automatic send_byte(input logic [7:0] value, input bit first, input bit last);
		rx_valid = 1'b1;
		rx_data  = value;
		for (int i = 0; i < byte_gap; i++) begin
			@(negedge clk);
			rx_valid = 1'b0;
			if (first && i == 0) begin
				led_prev = led; // this edge was still in idle.
			end else begin
				check_led_left();
			end
			// last write lands two cycles after the byte.
			check_value("cpu_rst while loading", int'(cpu_rst), (last && i >= 2) ? 0 : 1);
		end
	endtask

	task automatic cpu_write(input int addr, input logic [7:0] data);
		cpu_req.addr  = `LOADER_ADDR_W'(addr);
		cpu_req.wr    = 1'b1;
		cpu_req.wdata = data;
		@(negedge clk);
		cpu_req.wr = 1'b0;
		model_mem[addr] = data;
	endtask

	task automatic cpu_read(input int addr);
		cpu_req.addr = `LOADER_ADDR_W'(addr);
		cpu_req.wr   = 1'b0;
		@(negedge clk);
		check_value("cpu_rdata", int'(cpu_rdata), int'(model_mem[addr]));
	endtask

	task automatic dump_pass(input bit fast);
		logic [31:0] r;
		int          gap;
		int          delay;
		logic        extra_wr;
		dump_memory = 1'b1;
		@(negedge clk);
		dump_memory = 1'b0;
		check_value("cpu_rst after dump request", int'(cpu_rst), 1);
		gap = 1;
		for (int a = 0; a < depth; a++) begin
			while (!tx_wr && gap < wait_limit) begin
				@(negedge clk);
				gap++;
			end
			checks++;
			assert (tx_wr) else begin
				errors++;
				$display("tx_wr never came for address %0d within %0d cycles", a, wait_limit);
			end
			if (!tx_wr) begin
				break;
			end
			check_value("cycles from kick to tx_wr", gap, 2);
			check_value("tx_data", int'(tx_data), int'(model_mem[a]));
			r = lcg_next();
			delay = fast ? 1 : 1 + (int'(r[23:16]) % 5);
			repeat (delay) @(negedge clk);
			check_value("tx_data held", int'(tx_data), int'(model_mem[a]));
			tx_done = 1'b1;
			@(negedge clk);
			tx_done = 1'b0;
			gap = 1;
		end
		check_value("cpu_rst after last tx_done", int'(cpu_rst), 0);
		extra_wr = 1'b0;
		repeat (4) begin
			@(negedge clk);
			extra_wr = extra_wr | tx_wr;
		end
		check_value("tx_wr after last byte", int'(extra_wr), 0);
	endtask

	task automatic reset_state();
		check_value("cpu_rst", int'(cpu_rst), 1);
		check_value("tx_wr", int'(tx_wr), 0);
		check_value("led", int'(led), 1);
		report_test("reset_state");
	endtask

	task automatic full_load();
		logic [31:0] r;
		for (int a = 0; a < depth; a++) begin
			r = lcg_next();
			model_mem[a] = r[23:16];
			send_byte(r[23:16], a == 0, a == depth - 1);
		end
		report_test("full_load");
	endtask

	task automatic run_access();
		logic [31:0] r;
		// these bytes must not reach the ram.
		for (int k = 0; k < 3; k++) begin
			rx_valid = 1'b1;
			rx_data  = ~model_mem[k];
			@(negedge clk);
			rx_valid = 1'b0;
			repeat (byte_gap - 1) @(negedge clk);
			check_value("cpu_rst during run", int'(cpu_rst), 0);
		end
		r = lcg_next();
		cpu_write(3, r[23:16]);
		r = lcg_next();
		cpu_write(17, r[23:16]);
		r = lcg_next();
		cpu_write(40, r[23:16]);
		cpu_read(3);
		cpu_read(17);
		cpu_read(40);
		cpu_read(0);
		cpu_read(1);
		cpu_read(2);
		report_test("run_access");
	endtask

	task automatic first_dump();
		dump_pass(1'b0);
		report_test("first_dump");
	endtask

	task automatic fast_dump();
		dump_pass(1'b1);
		report_test("fast_dump");
	endtask

	initial begin
		rst         = 1'b1;
		rx_valid    = 1'b0;
		rx_data     = '0;
		dump_memory = 1'b0;
		tx_done     = 1'b0;
		cpu_req     = '0;
		led_prev    = '0;
		lcg_state   = 32'd91244;
		apply_reset();
		reset_state();
		full_load();
		run_access();
		first_dump();
		fast_dump();
		$display("tests: %0d, failed: %0d, checks: %0d, errors: %0d",
			tests, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/loader_pkg.sv
logic/loader_fsm.sv
logic/loader_counter.sv
logic/prog_ram.sv
logic/led_chaser.sv
logic/loader_top.sv
sim/loader_chk.sv
sim/loader_tb.sv
